// File: logic/la_pkg.sv
`default_nettype none

package la_pkg;

   // Widths of the register port
   localparam int reg_addr_w  = 8;
   localparam int reg_data_w  = 8;
   localparam int bytecnt_w   = 7;

   // Capture datapath widths
   localparam int count_w     = 16;
   localparam int channels    = 9;
   localparam int fifo_word_w = 2 * channels;  // Two samples per channel
   localparam int sel_w       = 3;

   typedef logic [reg_addr_w-1:0]  reg_addr_t;
   typedef logic [reg_data_w-1:0]  reg_data_t;
   typedef logic [bytecnt_w-1:0]   bytecnt_t;
   typedef logic [count_w-1:0]     count_t;
   typedef logic [channels-1:0]    probe_t;
   typedef logic [fifo_word_w-1:0] fifo_word_t;
   typedef logic [sel_w-1:0]       group_sel_t;
   typedef logic [sel_w-1:0]       trig_sel_t;

   // Register map
   localparam reg_addr_t addr_capture_group  = 8'd0;
   localparam reg_addr_t addr_status         = 8'd1;
   localparam reg_addr_t addr_trigger_source = 8'd2;
   localparam reg_addr_t addr_capture_depth  = 8'd3;  // Two bytes wide
   localparam reg_addr_t addr_downsample     = 8'd4;  // Two bytes wide
   localparam reg_addr_t addr_arm            = 8'd5;
   localparam reg_addr_t addr_manual_capture = 8'd6;

   // Probe groups
   localparam group_sel_t group_glitch = 3'd0;
   localparam group_sel_t group_io     = 3'd1;
   localparam group_sel_t group_user   = 3'd2;
   localparam group_sel_t group_debug  = 3'd3;
   localparam group_sel_t group_trace  = 3'd4;

   // Trigger sources
   localparam trig_sel_t trig_glitch_go      = 3'd0;
   localparam trig_sel_t trig_capture_active = 3'd1;
   localparam trig_sel_t trig_glitch_trigger = 3'd2;
   localparam trig_sel_t trig_hs1            = 3'd3;
   localparam trig_sel_t trig_debug0         = 3'd4;

   // Alternating ones and zeros for unused group codes
   localparam probe_t idle_pattern = 9'b1_0101_0101;

   // Bit positions inside the group buses
   localparam int hs1_bit    = 4;  // Within io_pins
   localparam int debug0_bit = 0;  // Within debug_bus

   // Status register bits
   localparam int status_armed_bit     = 0;
   localparam int status_capturing_bit = 1;

endpackage

`default_nettype wire

// File: logic/la_regs.sv
`default_nettype none

module la_regs import la_pkg::*; (
   input  wire         observer_clk,
   input  wire         reset,
   input  wire  reg_addr_t  reg_address,
   input  wire  bytecnt_t   reg_bytecnt,
   input  wire  reg_data_t  reg_datai,
   input  wire         reg_read,
   input  wire         reg_write,
   input  wire         capturing,
   input  wire         armed,
   input  wire         capture_go,
   input  wire         fifo_empty,
   output reg_data_t   reg_datao,
   output group_sel_t  capture_group,
   output trig_sel_t   trigger_source,
   output count_t      capture_depth,
   output count_t      downsample,
   output logic        manual_capture,
   output logic        arm,
   output logic        fifo_flush
);

   logic byte_sel;   // High byte of a 16-bit register
   logic wr_depth;
   logic wr_arm;

   assign byte_sel = reg_bytecnt[0];
   assign wr_depth = reg_write && (reg_address == addr_capture_depth);
   assign wr_arm   = reg_write && (reg_address == addr_arm);

   // Configuration registers
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         capture_group  <= group_glitch;
         trigger_source <= trig_glitch_go;
         downsample     <= '0;
         manual_capture <= 1'b0;
      end
      else if (reg_write) begin
         case (reg_address)
            addr_capture_group:  capture_group  <= reg_datai[2:0];
            addr_trigger_source: trigger_source <= reg_datai[2:0];
            addr_manual_capture: manual_capture <= reg_datai[0];
            addr_downsample: begin
               if (byte_sel)
                  downsample[15:8] <= reg_datai;
               else
                  downsample[7:0] <= reg_datai;
            end
            default: ;
         endcase
      end
   end

   // Capture depth loaded a byte at a time
   always_ff @(posedge observer_clk) begin
      if (wr_depth) begin
         if (byte_sel)
            capture_depth[15:8] <= reg_datai;
         else
            capture_depth[7:0] <= reg_datai;
      end
   end

   // A started capture consumes the arm bit
   always_ff @(posedge observer_clk) begin
      if (reset)
         arm <= 1'b0;
      else if (wr_arm)
         arm <= reg_datai[0];
      else if (capture_go)
         arm <= 1'b0;
   end

   // Flush the FIFO on arming until it reports empty
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         fifo_flush <= 1'b0;
      end
      else begin
         if (fifo_empty)
            fifo_flush <= 1'b0;
         else if (arm && !fifo_flush)
            fifo_flush <= 1'b1;
      end
   end

   // Read mux
   always_comb begin
      reg_datao = '0;
      if (reg_read) begin
         case (reg_address)
            addr_capture_group:  reg_datao = {5'b0, capture_group};
            addr_trigger_source: reg_datao = {5'b0, trigger_source};
            addr_manual_capture: reg_datao = {7'b0, manual_capture};
            addr_arm:            reg_datao = {7'b0, arm};
            addr_status: begin
               reg_datao[status_capturing_bit] = capturing;
               reg_datao[status_armed_bit]     = armed;
            end
            addr_capture_depth:
               reg_datao = byte_sel ? capture_depth[15:8] : capture_depth[7:0];
            addr_downsample:
               reg_datao = byte_sel ? downsample[15:8] : downsample[7:0];
            default: reg_datao = '0;  // Unmapped address
         endcase
      end
   end

endmodule

`default_nettype wire

// File: logic/la_trigger.sv
`default_nettype none

module la_trigger import la_pkg::*; (
   input  wire        observer_clk,
   input  wire        reset,
   input  wire  trig_sel_t  trigger_source,
   input  wire        manual_capture,
   input  wire        glitch_go,
   input  wire        capture_active,
   input  wire        glitch_trigger,
   input  wire        hs1,
   input  wire        debug0,
   input  wire        arm,
   input  wire        capturing,
   output logic       capture_go,
   output logic       armed,
   output logic       fifo_clear_write_flags
);

   logic trig_async;
   logic trig_meta;    // First synchronizer stage
   logic trig_sync;
   logic trig_last;    // Previous synchronized value for edge detect
   logic arm_d;

   always_comb begin
      case (trigger_source)
         trig_glitch_go:      trig_async = glitch_go;
         trig_capture_active: trig_async = capture_active;
         trig_glitch_trigger: trig_async = glitch_trigger;
         trig_hs1:            trig_async = hs1;
         trig_debug0:         trig_async = debug0;
         default:             trig_async = 1'b0;
      endcase
      trig_async = trig_async | manual_capture;
   end

   always_ff @(posedge observer_clk) begin
      if (reset) begin
         trig_meta  <= 1'b0;
         trig_sync  <= 1'b0;
         trig_last  <= 1'b0;
         capture_go <= 1'b0;
         arm_d      <= 1'b0;
         armed      <= 1'b0;
      end
      else begin
         trig_meta  <= trig_async;
         trig_sync  <= trig_meta;
         trig_last  <= trig_sync;
         // Never restart over a running capture
         capture_go <= trig_sync && !trig_last && armed && !capturing;
         arm_d      <= arm;
         if (capturing)
            armed <= 1'b0;
         else if (arm && !arm_d)
            armed <= 1'b1;
      end
   end

   assign fifo_clear_write_flags = arm_d;

endmodule

`default_nettype wire

// File: logic/la_probe_mux.sv
`default_nettype none

module la_probe_mux import la_pkg::*; (
   input  wire     observer_clk,
   input  wire  group_sel_t  capture_group,
   input  wire  probe_t      glitch_status,
   input  wire  probe_t      io_pins,
   input  wire  probe_t      user_io,
   input  wire  probe_t      debug_bus,
   input  wire  probe_t      trace_bus,
   output probe_t  probe_sample
);

   // Registered here so the capture logic sees one flop of selection delay
   always_ff @(posedge observer_clk) begin
      case (capture_group)
         group_glitch: probe_sample <= glitch_status;
         group_io:     probe_sample <= io_pins;
         group_user:   probe_sample <= user_io;
         group_debug:  probe_sample <= debug_bus;
         group_trace:  probe_sample <= trace_bus;
         default:      probe_sample <= idle_pattern;  // Recognizable in the dump
      endcase
   end

endmodule

`default_nettype wire

// File: logic/la_capture.sv
`default_nettype none

module la_capture import la_pkg::*; (
   input  wire        observer_clk,
   input  wire        reset,
   input  wire        capture_go,
   input  wire  count_t  capture_depth,
   input  wire  count_t  downsample,
   input  wire  probe_t  probe_sample,
   output logic       capturing,
   output logic       fifo_wr,
   output fifo_word_t fifo_wr_data
);

   count_t ds_ctr;        // Downsample counter
   logic   sample_en;     // One cycle every downsample+1 cycles
   count_t capture_count;
   logic   second;        // Next sample completes a pair
   logic   take_sample;
   probe_t sample_old;    // Earlier sample of the pair
   probe_t sample_new;

   assign take_sample = capturing && sample_en && !capture_go;

   // Rate divider
   always_ff @(posedge observer_clk) begin
      if (reset || capture_go) begin
         ds_ctr    <= '0;
         sample_en <= 1'b0;
      end
      else if (ds_ctr == downsample) begin
         ds_ctr    <= '0;
         sample_en <= 1'b1;
      end
      else begin
         ds_ctr    <= ds_ctr + 16'd1;
         sample_en <= 1'b0;
      end
   end

   always_ff @(posedge observer_clk) begin
      if (reset) begin
         capture_count <= '0;
         capturing     <= 1'b0;
         second        <= 1'b0;
         fifo_wr       <= 1'b0;
      end
      else if (capture_go) begin
         capture_count <= '0;
         capturing     <= 1'b1;
         second        <= 1'b0;
         fifo_wr       <= 1'b0;
      end
      else if (take_sample) begin
         second  <= !second;
         fifo_wr <= second;   // Pair done
         if (capture_count < capture_depth - 16'd1)
            capture_count <= capture_count + 16'd1;
         else
            capturing <= 1'b0;  // Depth reached
      end
      else begin
         fifo_wr <= 1'b0;
      end
   end

   // Two-deep history of every channel
   always_ff @(posedge observer_clk) begin
      if (take_sample) begin
         sample_old <= sample_new;
         sample_new <= probe_sample;
      end
   end

   // Channel k owns bit pair k with the older sample in the upper bit
   always_comb begin
      for (int k = 0; k < channels; k++) begin
         fifo_wr_data[2*k+1] = sample_old[k];
         fifo_wr_data[2*k]   = sample_new[k];
      end
   end

endmodule

`default_nettype wire

// File: logic/la_top.sv
`default_nettype none

module la_top import la_pkg::*; (
   input  wire         observer_clk,
   input  wire         reset,
   input  wire  reg_addr_t  reg_address,
   input  wire  bytecnt_t   reg_bytecnt,
   input  wire  reg_data_t  reg_datai,
   output reg_data_t   reg_datao,
   input  wire         reg_read,
   input  wire         reg_write,
   input  wire         glitch_go,
   input  wire         capture_active,
   input  wire         glitch_enable,
   input  wire         glitch_trigger,
   input  wire  probe_t     io_pins,
   input  wire  probe_t     user_io,
   input  wire  probe_t     debug_bus,
   input  wire  probe_t     trace_bus,
   output logic        fifo_wr,
   output fifo_word_t  fifo_wr_data,
   output logic        fifo_flush,
   input  wire         fifo_empty,
   output logic        fifo_clear_write_flags,
   output logic        fifo_clear_read_flags
);

   group_sel_t capture_group;
   trig_sel_t  trigger_source;
   count_t     capture_depth;
   count_t     downsample;
   logic       manual_capture;
   logic       arm;
   logic       armed;
   logic       capture_go;
   logic       capturing;
   probe_t     glitch_status;
   probe_t     probe_sample;

   // Glitch status lines in channels 0 to 3
   assign glitch_status = {5'b0, glitch_trigger, glitch_enable, capture_active, glitch_go};
   assign fifo_clear_read_flags = arm;

   la_regs la_regs_i (
      .observer_clk   (observer_clk),
      .reset          (reset),
      .reg_address    (reg_address),
      .reg_bytecnt    (reg_bytecnt),
      .reg_datai      (reg_datai),
      .reg_read       (reg_read),
      .reg_write      (reg_write),
      .capturing      (capturing),
      .armed          (armed),
      .capture_go     (capture_go),
      .fifo_empty     (fifo_empty),
      .reg_datao      (reg_datao),
      .capture_group  (capture_group),
      .trigger_source (trigger_source),
      .capture_depth  (capture_depth),
      .downsample     (downsample),
      .manual_capture (manual_capture),
      .arm            (arm),
      .fifo_flush     (fifo_flush)
   );

   la_trigger la_trigger_i (
      .observer_clk           (observer_clk),
      .reset                  (reset),
      .trigger_source         (trigger_source),
      .manual_capture         (manual_capture),
      .glitch_go              (glitch_go),
      .capture_active         (capture_active),
      .glitch_trigger         (glitch_trigger),
      .hs1                    (io_pins[hs1_bit]),      // HS1 rides in the IO group
      .debug0                 (debug_bus[debug0_bit]),
      .arm                    (arm),
      .capturing              (capturing),
      .capture_go             (capture_go),
      .armed                  (armed),
      .fifo_clear_write_flags (fifo_clear_write_flags)
   );

   la_probe_mux la_probe_mux_i (
      .observer_clk  (observer_clk),
      .capture_group (capture_group),
      .glitch_status (glitch_status),
      .io_pins       (io_pins),
      .user_io       (user_io),
      .debug_bus     (debug_bus),
      .trace_bus     (trace_bus),
      .probe_sample  (probe_sample)
   );

   la_capture la_capture_i (
      .observer_clk  (observer_clk),
      .reset         (reset),
      .capture_go    (capture_go),
      .capture_depth (capture_depth),
      .downsample    (downsample),
      .probe_sample  (probe_sample),
      .capturing     (capturing),
      .fifo_wr       (fifo_wr),
      .fifo_wr_data  (fifo_wr_data)
   );

endmodule

`default_nettype wire

// File: verif/la_tb_model.svh
`ifndef LA_TB_MODEL_SVH
`define LA_TB_MODEL_SVH

// Glitch group status lines sit in channels 0 to 3
function automatic probe_t glitch_group_value(input logic [3:0] lines);
   probe_t p;
   p = '0;
   p[3:0] = lines;  // go, active, enable, trigger from bit 0 up
   return p;
endfunction

function automatic probe_t group_value(input group_sel_t g, input probe_t glitch,
                                       input probe_t io, input probe_t user,
                                       input probe_t debug, input probe_t trace);
   case (g)
      3'd0:    return glitch;
      3'd1:    return io;
      3'd2:    return user;
      3'd3:    return debug;
      3'd4:    return trace;
      default: return idle_pattern;
   endcase
endfunction

// Bit pair k holds channel k with the earlier sample on top
function automatic fifo_word_t pair_word(input probe_t older, input probe_t newer);
   fifo_word_t w;
   for (int k = 0; k < 9; k++) begin
      w[2*k+1] = older[k];
      w[2*k]   = newer[k];
   end
   return w;
endfunction

function automatic int words_per_capture(input count_t depth);
   return depth / 2;
endfunction

function automatic int wr_spacing(input count_t ds);
   return 2 * (ds + 1);
endfunction

// Group and trigger registers keep three bits
function automatic reg_data_t reg_readback(input reg_addr_t addr, input reg_data_t data);
   if (addr == addr_capture_group || addr == addr_trigger_source)
      return data & 8'h07;
   return data;
endfunction

function automatic reg_data_t status_byte(input logic capturing, input logic armed);
   return {6'b0, capturing, armed};
endfunction

`endif

// File: verif/la_tb.sv
`default_nettype none

module la_tb import la_pkg::*; ();

   logic       observer_clk;
   logic       reset;
   reg_addr_t  reg_address;
   bytecnt_t   reg_bytecnt;
   reg_data_t  reg_datai;
   reg_data_t  reg_datao;
   logic       reg_read;
   logic       reg_write;
   logic       glitch_go, capture_active, glitch_enable, glitch_trigger;
   probe_t     io_pins, user_io, debug_bus, trace_bus;
   logic       fifo_wr;
   fifo_word_t fifo_wr_data;
   logic       fifo_flush;
   logic       fifo_empty;
   logic       fifo_clear_write_flags;
   logic       fifo_clear_read_flags;

   integer     seed = 24823;
   string      test_name;
   int         tests_run, tests_failed, errors, test_errors;
   int         word_count, cycle, last_wr, spacing;
   bit         have_last, check_data, check_spacing;
   fifo_word_t expected_word;

   `include "la_tb_model.svh"

   la_top la_top_i (.*);

   always #20 observer_clk = !observer_clk;

   task automatic report_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
      $display("error %s %s: expected 0x%0h, actual 0x%0h", test_name, what, exp, act);
      test_errors++;
      errors++;
   endtask

   task automatic fail_note(input string msg);
      $display("%s: %s", test_name, msg);
      test_errors++;
      errors++;
   endtask

   task automatic start_test(input string name);
      test_name = name;
      test_errors = 0;
      tests_run++;
   endtask

   task automatic end_test();
      if (test_errors == 0) begin
         $display("%s: passed", test_name);
      end
      else begin
         tests_failed++;
         $display("%s: failed with %0d errors", test_name, test_errors);
      end
   endtask

   // Words are sampled on the falling edge between DUT updates
   always @(negedge observer_clk) begin
      cycle++;
      if (!reset && fifo_wr) begin
         if (check_data && fifo_wr_data !== expected_word)
            report_value("word", expected_word, fifo_wr_data);
         if (check_spacing && have_last && cycle - last_wr != spacing)
            report_value("write spacing", spacing, cycle - last_wr);
         have_last = 1'b1;
         last_wr = cycle;
         word_count++;
      end
   end

   task automatic write_reg(input reg_addr_t addr, input bytecnt_t bcnt, input reg_data_t data);
      @(posedge observer_clk);
      reg_address <= addr;
      reg_bytecnt <= bcnt;
      reg_datai   <= data;
      reg_write   <= 1'b1;
      @(posedge observer_clk);
      reg_write   <= 1'b0;
   endtask

   task automatic write_reg16(input reg_addr_t addr, input count_t data);
      write_reg(addr, 7'd0, data[7:0]);
      write_reg(addr, 7'd1, data[15:8]);
   endtask

   task automatic check_reg(input reg_addr_t addr, input bytecnt_t bcnt, input reg_data_t exp);
      @(posedge observer_clk);
      reg_address <= addr;
      reg_bytecnt <= bcnt;
      reg_read    <= 1'b1;
      @(posedge observer_clk);
      if (reg_datao !== exp)
         report_value($sformatf("read of register %0d", addr), exp, reg_datao);
      reg_read <= 1'b0;
   endtask

   task automatic pulse_manual();
      write_reg(addr_manual_capture, 7'd0, 8'd1);
      write_reg(addr_manual_capture, 7'd0, 8'd0);
   endtask

   // Codes follow the trigger source numbering
   task automatic drive_trigger_input(input int which, input logic level);
      case (which)
         0:       glitch_go <= level;
         1:       capture_active <= level;
         2:       glitch_trigger <= level;
         3:       io_pins[hs1_bit] <= level;
         default: debug_bus[debug0_bit] <= level;
      endcase
   endtask

   task automatic pulse_input(input int which);
      @(posedge observer_clk);
      drive_trigger_input(which, 1'b1);
      repeat (3) @(posedge observer_clk);
      drive_trigger_input(which, 1'b0);
   endtask

   task automatic expect_words(input int base, input int n, input count_t ds);
      int waited;
      waited = 0;
      while (word_count - base < n && waited < 4000) begin
         @(posedge observer_clk);
         waited++;
      end
      if (word_count - base < n)
         fail_note($sformatf("timed out with %0d of %0d words", word_count - base, n));
      repeat (4 * (ds + 1) + 8) @(posedge observer_clk);  // Catch extra words
      if (word_count - base != n)
         report_value("word count", n, word_count - base);
   endtask

   task automatic expect_no_words(input int base);
      repeat (20) @(posedge observer_clk);
      if (word_count != base)
         report_value("words without capture", 0, word_count - base);
   endtask

   task automatic manual_capture_run(input count_t depth, input count_t ds);
      int base;
      base = word_count;
      have_last = 1'b0;
      write_reg16(addr_capture_depth, depth);
      write_reg16(addr_downsample, ds);
      write_reg(addr_trigger_source, 7'd0, 8'd7);  // Unused code leaves only the manual trigger
      write_reg(addr_arm, 7'd0, 8'd1);
      pulse_manual();
      expect_words(base, words_per_capture(depth), ds);
   endtask

   task automatic wait_flush(input logic level);
      int waited;
      waited = 0;
      while (fifo_flush !== level && waited < 20) begin
         @(posedge observer_clk);
         waited++;
      end
      if (fifo_flush !== level)
         fail_note($sformatf("fifo_flush did not reach %0b within 20 cycles", level));
   endtask

   initial begin
      reg_data_t  g;
      reg_data_t  t;
      count_t     depth;
      count_t     ds;
      logic [3:0] gl;
      probe_t     iov, uv, dv, tv;
      int         base;
      observer_clk = 1'b0;
      reset = 1'b1;
      reg_address = '0;
      reg_bytecnt = '0;
      reg_datai = '0;
      reg_read = 1'b0;
      reg_write = 1'b0;
      glitch_go = 1'b0;
      capture_active = 1'b0;
      glitch_enable = 1'b0;
      glitch_trigger = 1'b0;
      io_pins = '0;
      user_io = '0;
      debug_bus = '0;
      trace_bus = '0;
      fifo_empty = 1'b1;
      repeat (3) @(posedge observer_clk);
      reset <= 1'b0;

      start_test("register readback");
      for (int i = 0; i < 4; i++) begin
         g = $random(seed);
         t = $random(seed);
         depth = $random(seed);
         ds = $random(seed);
         write_reg(addr_capture_group, 7'd0, g);
         write_reg(addr_trigger_source, 7'd0, t);
         write_reg16(addr_capture_depth, depth);
         write_reg16(addr_downsample, ds);
         check_reg(addr_capture_group, 7'd0, reg_readback(addr_capture_group, g));
         check_reg(addr_trigger_source, 7'd0, reg_readback(addr_trigger_source, t));
         check_reg(addr_capture_depth, 7'd0, depth[7:0]);
         check_reg(addr_capture_depth, 7'd1, depth[15:8]);
         check_reg(addr_downsample, 7'd0, ds[7:0]);
         check_reg(addr_downsample, 7'd1, ds[15:8]);
      end
      end_test();

      start_test("capture contents");
      check_data = 1'b1;
      for (int i = 0; i < 5; i++) begin
         g = {5'b0, 3'($random(seed))};
         gl = $random(seed);
         iov = $random(seed);
         uv = $random(seed);
         dv = $random(seed);
         tv = $random(seed);
         @(posedge observer_clk);
         {glitch_trigger, glitch_enable, capture_active, glitch_go} <= gl;
         io_pins <= iov;
         user_io <= uv;
         debug_bus <= dv;
         trace_bus <= tv;
         expected_word = pair_word(group_value(g[2:0], glitch_group_value(gl), iov, uv, dv, tv),
                                   group_value(g[2:0], glitch_group_value(gl), iov, uv, dv, tv));
         write_reg(addr_capture_group, 7'd0, g);
         manual_capture_run(16'd4 + 16'd2 * 16'({$random(seed)} % 19), 16'd0);
      end
      check_data = 1'b0;
      end_test();

      start_test("downsample spacing");
      check_spacing = 1'b1;
      for (int i = 0; i < 4; i++) begin
         ds = {$random(seed)} % 6;
         depth = 16'd4 + 16'd2 * 16'({$random(seed)} % 5);
         spacing = wr_spacing(ds);
         manual_capture_run(depth, ds);
      end
      check_spacing = 1'b0;
      end_test();

      start_test("arming rules");
      base = word_count;
      write_reg(addr_trigger_source, 7'd0, 8'd7);
      pulse_manual();
      expect_no_words(base);  // Not armed yet
      manual_capture_run(16'd6, 16'd1);
      check_reg(addr_status, 7'd0, status_byte(1'b0, 1'b0));
      check_reg(addr_arm, 7'd0, 8'd0);
      base = word_count;
      pulse_manual();
      expect_no_words(base);
      end_test();

      start_test("trigger sources");
      @(posedge observer_clk);
      {glitch_trigger, glitch_enable, capture_active, glitch_go} <= 4'b0;
      io_pins <= '0;
      debug_bus <= '0;
      for (int src = 0; src < 5; src++) begin
         write_reg16(addr_capture_depth, 16'd4);
         write_reg16(addr_downsample, 16'd0);
         write_reg(addr_trigger_source, 7'd0, reg_data_t'(src));
         write_reg(addr_arm, 7'd0, 8'd1);
         for (int other = 0; other < 5; other++) begin
            if (other != src) begin
               base = word_count;
               pulse_input(other);
               expect_no_words(base);
            end
         end
         base = word_count;
         pulse_input(src);
         expect_words(base, words_per_capture(16'd4), 16'd0);
      end
      end_test();

      start_test("fifo flush");
      @(posedge observer_clk);
      fifo_empty <= 1'b0;
      write_reg(addr_arm, 7'd0, 8'd1);
      wait_flush(1'b1);
      if (fifo_clear_read_flags !== 1'b1)
         report_value("fifo_clear_read_flags", 1, fifo_clear_read_flags);
      @(posedge observer_clk);
      fifo_empty <= 1'b1;
      wait_flush(1'b0);
      write_reg(addr_arm, 7'd0, 8'd0);
      @(negedge observer_clk);
      if (fifo_clear_read_flags !== 1'b0)
         report_value("fifo_clear_read_flags", 0, fifo_clear_read_flags);
      if (fifo_clear_write_flags !== 1'b1)
         report_value("fifo_clear_write_flags", 1, fifo_clear_write_flags);  // One cycle late
      @(negedge observer_clk);
      if (fifo_clear_write_flags !== 1'b0)
         report_value("fifo_clear_write_flags", 0, fifo_clear_write_flags);
      end_test();

      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+verif
logic/la_pkg.sv
logic/la_regs.sv
logic/la_trigger.sv
logic/la_probe_mux.sv
logic/la_capture.sv
logic/la_top.sv
verif/la_tb.sv

// File: Bender.yml
package:
  name: la_capture

sources:
  - logic/la_pkg.sv
  - logic/la_regs.sv
  - logic/la_trigger.sv
  - logic/la_probe_mux.sv
  - logic/la_capture.sv
  - logic/la_top.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/la_tb.sv
